//--- Bender.yml
package:
  name: core_main

sources:
  - files:
      - hdl/core_pkg.sv
      - hdl/dependency_decoder.sv
      - hdl/issue_scheduler.sv
      - hdl/core_executer.sv
      - hdl/register_merge.sv
      - hdl/core_main.sv
  - target: simulation
    files:
      - sim/core_properties.sv
      - sim/core_tb.sv

//--- filelist.f
hdl/core_pkg.sv
hdl/dependency_decoder.sv
hdl/issue_scheduler.sv
hdl/core_executer.sv
hdl/register_merge.sv
hdl/core_main.sv
sim/core_properties.sv
sim/core_tb.sv

//--- hdl/core_executer.sv
`default_nettype none

module core_executer import core_pkg::*; (
	input logic main_clk,
	input logic rst_n,
	input logic start,
	input opcode_t issue_op,
	input logic [3:0] issue_rd,
	input logic [DATA_W-1:0] issue_a,
	input logic [DATA_W-1:0] issue_b,
	input logic [7:0] issue_imm,
	input logic [PC_W-1:0] issue_pc,
	output logic busy,
	output logic write_en,
	output logic [REG_IDX_W-1:0] write_index,
	output logic [DATA_W-1:0] write_value,
	output logic redirect,
	output logic [PC_W-1:0] redirect_pc
);

	logic [$clog2(MUL_LATENCY)-1:0] count;
	opcode_t op;
	logic [3:0] rd;
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] b;
	logic [7:0] imm;
	logic [PC_W-1:0] pc;
	logic done;
	logic writes_reg;

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			count <= '0;
		end else if (start) begin
			busy <= 1'b1;
			// a multiply sits MUL_LATENCY cycles, everything else finishes next cycle
			count <= (issue_op == OP_MUL) ? ($bits(count))'(MUL_LATENCY - 1) : '0;
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			count <= count - 1'b1;
		end
	end

	// payload is only meaningful while busy
	always_ff @(posedge main_clk) begin
		if (start) begin
			op <= issue_op;
			rd <= issue_rd;
			a <= issue_a;
			b <= issue_b;
			imm <= issue_imm;
			pc <= issue_pc;
		end
	end

	assign done = busy && (count == '0);

	always_comb begin
		writes_reg = 1'b1;
		write_value = '0;
		case (op)
			OP_LDI: write_value = DATA_W'(imm);
			OP_ADD: write_value = a + b;
			OP_SUB: write_value = a - b;
			OP_AND: write_value = a & b;
			OP_XOR: write_value = a ^ b;
			OP_SHL: write_value = a << imm[3:0];
			OP_MUL: write_value = a * b;
			OP_SPADD: write_value = a + DATA_W'($signed(imm));
			OP_SPGET: write_value = a;
			default: writes_reg = 1'b0;
		endcase
	end

	assign write_en = done && writes_reg;
	assign write_index = (op == OP_SPADD) ? REG_IDX_W'(SP_INDEX) : {1'b0, rd};

	// a taken branch adds the signed offset, otherwise fall through
	assign redirect = done && (op == OP_JNZ);
	assign redirect_pc = (a != '0) ? pc + PC_W'($signed(imm)) : pc + 1'b1;

endmodule

`default_nettype wire

//--- hdl/core_main.sv
`default_nettype none

module core_main import core_pkg::*; (
	input logic main_clk,
	input logic rst_n,
	output logic [PC_W-1:0] instr_addr,
	input logic [DATA_W-1:0] instr_data,
	output logic halted,
	output logic [DATA_W-1:0] debug_user_reg [NUM_USER_REGS],
	output logic [DATA_W-1:0] debug_stack_pointer
);

	opcode_t opcode;
	logic [3:0] rd;
	logic [3:0] rs;
	logic [7:0] imm8;
	core_mask_t read_mask;
	core_mask_t write_mask;

	logic [DATA_W-1:0] core_values [NUM_CORE_VALUES];

	logic [NUM_EXECUTERS-1:0] start;
	logic [NUM_EXECUTERS-1:0] busy;
	logic [NUM_EXECUTERS-1:0] redirect;
	logic [PC_W-1:0] redirect_pc [NUM_EXECUTERS];
	logic [NUM_EXECUTERS-1:0] write_en;
	logic [REG_IDX_W-1:0] write_index [NUM_EXECUTERS];
	logic [DATA_W-1:0] write_value [NUM_EXECUTERS];

	opcode_t issue_op;
	logic [3:0] issue_rd;
	logic [DATA_W-1:0] issue_a;
	logic [DATA_W-1:0] issue_b;
	logic [7:0] issue_imm;
	logic [PC_W-1:0] issue_pc;

	dependency_decoder u_decoder (
		.instr_data (instr_data),
		.opcode     (opcode),
		.rd         (rd),
		.rs         (rs),
		.imm8       (imm8),
		.read_mask  (read_mask),
		.write_mask (write_mask)
	);

	issue_scheduler u_scheduler (
		.main_clk    (main_clk),
		.rst_n       (rst_n),
		.opcode      (opcode),
		.rd          (rd),
		.rs          (rs),
		.imm8        (imm8),
		.read_mask   (read_mask),
		.write_mask  (write_mask),
		.core_values (core_values),
		.busy        (busy),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.instr_addr  (instr_addr),
		.start       (start),
		.issue_op    (issue_op),
		.issue_rd    (issue_rd),
		.issue_a     (issue_a),
		.issue_b     (issue_b),
		.issue_imm   (issue_imm),
		.issue_pc    (issue_pc),
		.halted      (halted)
	);

	for (genvar i = 0; i < NUM_EXECUTERS; i++) begin : g_exec
		core_executer u_executer (
			.main_clk    (main_clk),
			.rst_n       (rst_n),
			.start       (start[i]),
			.issue_op    (issue_op),
			.issue_rd    (issue_rd),
			.issue_a     (issue_a),
			.issue_b     (issue_b),
			.issue_imm   (issue_imm),
			.issue_pc    (issue_pc),
			.busy        (busy[i]),
			.write_en    (write_en[i]),
			.write_index (write_index[i]),
			.write_value (write_value[i]),
			.redirect    (redirect[i]),
			.redirect_pc (redirect_pc[i])
		);
	end

	register_merge u_merge (
		.main_clk    (main_clk),
		.rst_n       (rst_n),
		.write_en    (write_en),
		.write_index (write_index),
		.write_value (write_value),
		.core_values (core_values)
	);

	for (genvar j = 0; j < NUM_USER_REGS; j++) begin : g_debug
		assign debug_user_reg[j] = core_values[j];
	end
	assign debug_stack_pointer = core_values[SP_INDEX];

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

package core_pkg;

	// data path and register file
	localparam int DATA_W = 16;
	localparam int NUM_USER_REGS = 16;
	localparam int NUM_CORE_VALUES = NUM_USER_REGS + 1;
	localparam int SP_INDEX = NUM_USER_REGS;
	localparam int REG_IDX_W = 5;

	// program counter and fetch address
	localparam int PC_W = 8;

	// execution slots
	localparam int NUM_EXECUTERS = 4;
	localparam int EXEC_IDX_W = 2;

	// cycles a multiply holds its slot, counted from the start pulse to the write
	localparam int MUL_LATENCY = 4;

	// instruction opcodes, taken from bits [15:12] of the instruction word
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LDI = 4'd1,
		OP_ADD = 4'd2,
		OP_SUB = 4'd3,
		OP_AND = 4'd4,
		OP_XOR = 4'd5,
		OP_SHL = 4'd6,
		OP_MUL = 4'd7,
		OP_JNZ = 4'd8,
		OP_SPADD = 4'd9,
		OP_SPGET = 4'd10,
		OP_HALT = 4'd15
	} opcode_t;

	// one bit per core value; bit SP_INDEX stands for the stack pointer
	typedef logic [NUM_CORE_VALUES-1:0] core_mask_t;

endpackage

`default_nettype wire

//--- hdl/dependency_decoder.sv
`default_nettype none

module dependency_decoder import core_pkg::*; (
	input logic [DATA_W-1:0] instr_data,
	output opcode_t opcode,
	output logic [3:0] rd,
	output logic [3:0] rs,
	output logic [7:0] imm8,
	output core_mask_t read_mask,
	output core_mask_t write_mask
);

	core_mask_t rd_bit;
	core_mask_t rs_bit;
	core_mask_t sp_bit;

	assign rd = instr_data[11:8];
	assign rs = instr_data[7:4];
	assign imm8 = instr_data[7:0];

	assign rd_bit = core_mask_t'(1) << rd;
	assign rs_bit = core_mask_t'(1) << rs;
	assign sp_bit = core_mask_t'(1) << SP_INDEX;

	// unassigned opcodes decode as nop
	always_comb begin
		case (instr_data[15:12])
			OP_LDI, OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_SHL, OP_MUL,
			OP_JNZ, OP_SPADD, OP_SPGET, OP_HALT: opcode = opcode_t'(instr_data[15:12]);
			default: opcode = OP_NOP;
		endcase
	end

	always_comb begin
		read_mask = '0;
		write_mask = '0;
		case (opcode)
			OP_LDI: write_mask = rd_bit;
			OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_MUL: begin
				read_mask = rd_bit | rs_bit;
				write_mask = rd_bit;
			end
			OP_SHL: begin
				read_mask = rd_bit;
				write_mask = rd_bit;
			end
			OP_JNZ: read_mask = rd_bit;
			OP_SPADD: begin
				read_mask = sp_bit;
				write_mask = sp_bit;
			end
			OP_SPGET: begin
				read_mask = sp_bit;
				write_mask = rd_bit;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/issue_scheduler.sv
`default_nettype none

module issue_scheduler import core_pkg::*; (
	input logic main_clk,
	input logic rst_n,
	input opcode_t opcode,
	input logic [3:0] rd,
	input logic [3:0] rs,
	input logic [7:0] imm8,
	input core_mask_t read_mask,
	input core_mask_t write_mask,
	input logic [DATA_W-1:0] core_values [NUM_CORE_VALUES],
	input logic [NUM_EXECUTERS-1:0] busy,
	input logic [NUM_EXECUTERS-1:0] redirect,
	input logic [PC_W-1:0] redirect_pc [NUM_EXECUTERS],
	output logic [PC_W-1:0] instr_addr,
	output logic [NUM_EXECUTERS-1:0] start,
	output opcode_t issue_op,
	output logic [3:0] issue_rd,
	output logic [DATA_W-1:0] issue_a,
	output logic [DATA_W-1:0] issue_b,
	output logic [7:0] issue_imm,
	output logic [PC_W-1:0] issue_pc,
	output logic halted
);

	logic [PC_W-1:0] pc;
	logic jump_stall;
	logic halted_issue;
	core_mask_t pending_mask [NUM_EXECUTERS];
	core_mask_t busy_writes;
	logic [EXEC_IDX_W-1:0] free_slot;
	logic free_found;
	logic hazard;
	logic can_issue;
	logic needs_slot;
	logic [PC_W-1:0] redirect_target;

	// a slot's pending writes only count while that slot is still busy
	always_comb begin
		busy_writes = '0;
		for (int i = 0; i < NUM_EXECUTERS; i++) begin
			if (busy[i])
				busy_writes = busy_writes | pending_mask[i];
		end
	end

	// walk downwards so the lowest idle slot wins
	always_comb begin
		free_found = 1'b0;
		free_slot = '0;
		for (int i = NUM_EXECUTERS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				free_found = 1'b1;
				free_slot = EXEC_IDX_W'(i);
			end
		end
	end

	assign hazard = |((read_mask | write_mask) & busy_writes);
	assign can_issue = !halted_issue && !jump_stall && free_found && !hazard;
	assign needs_slot = (opcode != OP_NOP) && (opcode != OP_HALT);

	always_comb begin
		start = '0;
		if (can_issue && needs_slot)
			start[free_slot] = 1'b1;
	end

	always_comb begin
		redirect_target = '0;
		for (int i = 0; i < NUM_EXECUTERS; i++)
			redirect_target = redirect_target | (redirect_pc[i] & {PC_W{redirect[i]}});
	end

	// the sp-based ops carry the stack pointer in operand a
	assign issue_a = (opcode == OP_SPADD || opcode == OP_SPGET) ? core_values[SP_INDEX] :
		core_values[rd];
	assign issue_b = core_values[rs];
	assign issue_op = opcode;
	assign issue_rd = rd;
	assign issue_imm = imm8;
	assign issue_pc = pc;
	assign instr_addr = pc;

	assign halted = halted_issue && !(|busy);

	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			pc <= '0;
			jump_stall <= 1'b0;
			halted_issue <= 1'b0;
		end else if (|redirect) begin
			pc <= redirect_target;
			jump_stall <= 1'b0;
		end else if (can_issue) begin
			case (opcode)
				OP_JNZ: jump_stall <= 1'b1;
				// pc stays on the halt word
				OP_HALT: halted_issue <= 1'b1;
				default: pc <= pc + 1'b1;
			endcase
		end
	end

	always_ff @(posedge main_clk) begin
		for (int i = 0; i < NUM_EXECUTERS; i++) begin
			if (!rst_n)
				pending_mask[i] <= '0;
			else if (start[i])
				pending_mask[i] <= write_mask;
			else if (!busy[i])
				pending_mask[i] <= '0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/register_merge.sv
`default_nettype none

module register_merge import core_pkg::*; (
	input logic main_clk,
	input logic rst_n,
	input logic [NUM_EXECUTERS-1:0] write_en,
	input logic [REG_IDX_W-1:0] write_index [NUM_EXECUTERS],
	input logic [DATA_W-1:0] write_value [NUM_EXECUTERS],
	output logic [DATA_W-1:0] core_values [NUM_CORE_VALUES]
);

	// the scheduler keeps write sets of busy slots disjoint, so port order does not matter
	always_ff @(posedge main_clk) begin
		if (!rst_n) begin
			for (int j = 0; j < NUM_CORE_VALUES; j++)
				core_values[j] <= '0;
		end else begin
			for (int i = 0; i < NUM_EXECUTERS; i++) begin
				if (write_en[i])
					core_values[write_index[i]] <= write_value[i];
			end
			// stack pointer stays word aligned
			core_values[SP_INDEX][0] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- sim/core_properties.sv
`default_nettype none

module core_properties import core_pkg::*; (
	input logic main_clk,
	input logic rst_n,
	input logic [NUM_EXECUTERS-1:0] write_en,
	input logic [REG_IDX_W-1:0] write_index [NUM_EXECUTERS],
	input logic [DATA_W-1:0] core_values [NUM_CORE_VALUES]
);
	timeunit 1ns;
	timeprecision 1ps;

	logic index_clash;

	always_comb begin
		index_clash = 1'b0;
		for (int i = 0; i < NUM_EXECUTERS; i++) begin
			for (int j = i + 1; j < NUM_EXECUTERS; j++) begin
				if (write_en[i] && write_en[j] && write_index[i] == write_index[j])
					index_clash = 1'b1;
			end
		end
	end

	single_writer: assert property (@(posedge main_clk) disable iff (!rst_n) !index_clash)
		else $error("two executers wrote the same core value in one cycle");

	sp_aligned: assert property (@(posedge main_clk) disable iff (!rst_n)
		core_values[SP_INDEX][0] == 1'b0)
		else $error("stack pointer bit 0 is set");

	// the executers come out of reset idle
	quiet_after_reset: assert property (@(posedge main_clk) !rst_n |=> write_en == '0)
		else $error("write port active in the cycle after reset");

endmodule

bind register_merge core_properties u_properties (
	.main_clk    (main_clk),
	.rst_n       (rst_n),
	.write_en    (write_en),
	.write_index (write_index),
	.core_values (core_values)
);

`default_nettype wire

//--- sim/core_tb.sv
`default_nettype none

module core_tb import core_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HALT_TIMEOUT = 2000;
	localparam int NUM_PROGRAMS = 30;
	localparam int PROG_LEN = 40;

	logic main_clk;
	logic rst_n;
	logic [PC_W-1:0] instr_addr;
	logic [DATA_W-1:0] instr_data;
	logic halted;
	logic [DATA_W-1:0] debug_user_reg [NUM_USER_REGS];
	logic [DATA_W-1:0] debug_stack_pointer;

	logic [DATA_W-1:0] rom [256];
	logic [DATA_W-1:0] model_regs [NUM_USER_REGS];
	logic [DATA_W-1:0] model_sp;
	logic [PC_W-1:0] model_pc;
	int seed;
	int value_errors;
	int timeout_errors;
	bit halt_seen;

	core_main DUT (
		.main_clk            (main_clk),
		.rst_n               (rst_n),
		.instr_addr          (instr_addr),
		.instr_data          (instr_data),
		.halted              (halted),
		.debug_user_reg      (debug_user_reg),
		.debug_stack_pointer (debug_stack_pointer)
	);

	assign instr_data = rom[instr_addr];

	always #4 main_clk = ~main_clk;

	// kind 1 favours mul, kind 2 forward jnz and kind 3 spadd
	task automatic random_instr(input int kind, output logic [DATA_W-1:0] word);
		logic [3:0] op;
		logic [3:0] rd;
		logic [7:0] imm;
		int pick;
		pick = {$random(seed)} % 16;
		rd = $random(seed);
		imm = $random(seed);
		case (pick)
			0, 1, 2, 3: op = OP_LDI;
			4: op = OP_ADD;
			5: op = OP_SUB;
			6: op = OP_AND;
			7: op = OP_XOR;
			8: op = OP_SHL;
			9: op = OP_SPGET;
			// opcodes 11 to 14 are unassigned and behave as nop
			10: op = imm[0] ? OP_NOP : 4'd11 + 4'(imm[2:1]);
			default: begin
				case (kind)
					1: op = OP_MUL;
					2: op = OP_JNZ;
					3: op = OP_SPADD;
					default: op = OP_XOR;
				endcase
			end
		endcase
		// multiplies write the upper eight registers from the lower eight
		if (op == OP_MUL) begin
			rd = {1'b1, rd[2:0]};
			imm[7] = 1'b0;
		end
		if (op == OP_JNZ)
			imm = 8'd1 + {5'd0, imm[2:0]};
		word = {op, rd, imm};
	endtask

	// sequential reference: one instruction at a time from pc 0 up to the halt word
	task automatic run_model();
		logic [DATA_W-1:0] word;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [7:0] imm;
		logic [PC_W-1:0] next_pc;
		int steps;
		steps = 0;
		word = rom[model_pc];
		while (word[15:12] != OP_HALT && steps < 256) begin
			rd = word[11:8];
			rs = word[7:4];
			imm = word[7:0];
			next_pc = model_pc + 8'd1;
			case (word[15:12])
				OP_LDI: model_regs[rd] = {8'h00, imm};
				OP_ADD: model_regs[rd] = model_regs[rd] + model_regs[rs];
				OP_SUB: model_regs[rd] = model_regs[rd] - model_regs[rs];
				OP_AND: model_regs[rd] = model_regs[rd] & model_regs[rs];
				OP_XOR: model_regs[rd] = model_regs[rd] ^ model_regs[rs];
				OP_SHL: model_regs[rd] = model_regs[rd] << imm[3:0];
				OP_MUL: model_regs[rd] = model_regs[rd] * model_regs[rs];
				OP_JNZ: begin
					if (model_regs[rd] != 16'h0000)
						next_pc = model_pc + imm;
				end
				OP_SPADD: model_sp = (model_sp + {{8{imm[7]}}, imm}) & 16'hfffe;
				OP_SPGET: model_regs[rd] = model_sp;
				default: ;
			endcase
			model_pc = next_pc;
			word = rom[model_pc];
			steps++;
		end
	endtask

	task automatic check_state(input int prog);
		for (int r = 0; r < NUM_USER_REGS; r++) begin
			if (debug_user_reg[r] !== model_regs[r]) begin
				$display("FAILED at %0t: program %0d r%0d is %h, expected %h",
					$time, prog, r, debug_user_reg[r], model_regs[r]);
				value_errors++;
			end
		end
		if (debug_stack_pointer !== model_sp || debug_stack_pointer[0] !== 1'b0) begin
			$display("FAILED at %0t: program %0d sp is %h, expected %h",
				$time, prog, debug_stack_pointer, model_sp);
			value_errors++;
		end
		if (instr_addr !== model_pc) begin
			$display("FAILED at %0t: program %0d instr_addr is %h, expected %h",
				$time, prog, instr_addr, model_pc);
			value_errors++;
		end
	endtask

	task automatic wait_for_halt(input int prog, output bit seen);
		int cycles;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < HALT_TIMEOUT) begin
			@(negedge main_clk);
			seen = (halted === 1'b1);
			cycles++;
		end
		if (!seen) begin
			$display("timeout: program %0d did not halt within %0d cycles", prog, HALT_TIMEOUT);
			timeout_errors++;
		end
	endtask

	initial begin
		main_clk = 1'b0;
		rst_n = 1'b0;
		seed = 32'h0ff3a20b;
		value_errors = 0;
		timeout_errors = 0;
		// halt words carry their own address in the low byte
		for (int a = 0; a < 256; a++)
			rom[a] = {OP_HALT, 4'h0, 8'(a)};
		for (int p = 0; p < NUM_PROGRAMS; p++) begin
			@(negedge main_clk);
			rst_n = 1'b0;
			for (int a = 0; a < PROG_LEN; a++)
				random_instr(p % 4, rom[a]);
			for (int r = 0; r < NUM_USER_REGS; r++)
				model_regs[r] = '0;
			model_sp = '0;
			model_pc = '0;
			repeat (3) @(negedge main_clk);
			// state right after reset matches an all-zero model
			if (halted !== 1'b0) begin
				$display("FAILED at %0t: program %0d halted high during reset", $time, p);
				value_errors++;
			end
			check_state(p);
			run_model();
			rst_n = 1'b1;
			wait_for_halt(p, halt_seen);
			if (halt_seen) begin
				check_state(p);
				repeat (10) begin
					@(negedge main_clk);
					if (halted !== 1'b1) begin
						$display("FAILED at %0t: program %0d halted dropped", $time, p);
						value_errors++;
					end
					check_state(p);
				end
			end
		end
		$display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
